/* hw/board_pkg.sv */
`default_nettype none

package board_pkg;

    // **************************************************
    // Divider counts, sized for simulation.
    // **************************************************
    localparam int CORE_FAST_DIV = 4;
    localparam int CORE_SLOW_DIV = 16;
    localparam int SCAN_DIV = 8;
    localparam int NUM_DIGITS = 8;

    // **************************************************
    // Switch word
    // **************************************************

    // Register-file view, upper five switches pick the register.
    typedef struct packed {
        logic [4:0] reg_idx;
        logic [6:0] spare;
        logic [2:0] disp_sel;
        logic       freq_sel;
    } sw_reg_view_t;

    // Data-memory view, upper ten switches pick the word.
    typedef struct packed {
        logic [9:0] mem_word;
        logic [1:0] spare;
        logic [2:0] disp_sel;
        logic       freq_sel;
    } sw_mem_view_t;

    // Same sixteen switches, two readings.
    typedef union packed {
        sw_reg_view_t reg_view;
        sw_mem_view_t mem_view;
    } sw_word_u;

endpackage

`default_nettype wire

/* hw/core_pkg.sv */
`default_nettype none

package core_pkg;

    // **************************************************
    // Display source select.
    // **************************************************
    typedef enum logic [2:0] {
        DISP_CORE     = 3'd0,
        DISP_CYCLES   = 3'd1,
        DISP_JUMPS    = 3'd2,
        DISP_BRANCHES = 3'd3,
        DISP_TAKEN    = 3'd4,
        DISP_PC       = 3'd5,
        DISP_REG      = 3'd6,
        DISP_MEM      = 3'd7
    } disp_sel_e;

    // **************************************************
    // Core interface
    // **************************************************

    // Status from the core, event flags valid in the step cycle.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] reg_data;
        logic [31:0] mem_data;
        logic [31:0] display;
        logic        halt;
        logic        is_jump;
        logic        is_branch;
        logic        branched;
    } core_status_t;

    // Debug lookup request. mem_addr is a byte address.
    typedef struct packed {
        logic [4:0]  reg_idx;
        logic [31:0] mem_addr;
    } core_dbg_req_t;

    // Execution statistics.
    typedef struct packed {
        logic [31:0] cycles;
        logic [31:0] jumps;
        logic [31:0] branches;
        logic [31:0] taken;
    } exec_stats_t;

endpackage

`default_nettype wire

/* hw/board_inputs.sv */
`timescale 1ns/1ps
`default_nettype none

module board_inputs
    import board_pkg::*;
    import core_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic [15:0]   swt,
    input  logic          resume,
    output logic          freq_sel,
    output disp_sel_e     disp_sel,
    output core_dbg_req_t core_dbg,
    output logic          resume_pulse
);

    logic [15:0] swt_meta;
    logic [15:0] swt_sync;
    logic        resume_meta;
    logic        resume_sync;
    logic        resume_prev;
    sw_word_u    sw;

    // **************************************************
    // Two-flop synchronizers
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            swt_meta    <= '0;
            swt_sync    <= '0;
            resume_meta <= 1'b0;
            resume_sync <= 1'b0;
        end else begin
            swt_meta    <= swt;
            swt_sync    <= swt_meta;
            resume_meta <= resume;
            resume_sync <= resume_meta;
        end
    end

    // Rising edge of the button, registered.
    always_ff @(posedge clk) begin
        if (rst) begin
            resume_prev  <= 1'b0;
            resume_pulse <= 1'b0;
        end else begin
            resume_prev  <= resume_sync;
            resume_pulse <= resume_sync & ~resume_prev;
        end
    end

    // **************************************************
    // Switch word decode
    // **************************************************
    assign sw = swt_sync;

    assign freq_sel          = sw.reg_view.freq_sel;
    assign disp_sel          = disp_sel_e'(sw.reg_view.disp_sel);
    assign core_dbg.reg_idx  = sw.reg_view.reg_idx;
    // Word index to byte address.
    assign core_dbg.mem_addr = {20'd0, sw.mem_view.mem_word, 2'b00};

endmodule

`default_nettype wire

/* hw/rate_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module rate_divider #(
    parameter int DIV = 4
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CNT_W-1:0] cnt;

    // One tick per DIV cycles, first one DIV cycles out of reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == CNT_W'(DIV - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/run_control.sv */
`timescale 1ns/1ps
`default_nettype none

module run_control (
    input  logic clk,
    input  logic rst,
    input  logic tick,
    input  logic halt,
    input  logic resume_pulse,
    output logic core_step
);

    logic running;

    // **************************************************
    // Run/halt state
    // **************************************************

    // The core runs out of reset.
    // A halted step still goes out, then the shell stops.
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b1;
        end else if (resume_pulse) begin
            running <= 1'b1;
        end else if (core_step && halt) begin
            running <= 1'b0;
        end
    end

    // Step strobe.
    assign core_step = tick & running;

endmodule

`default_nettype wire

/* hw/exec_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_counters
    import core_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         core_step,
    input  core_status_t core_stat,
    output exec_stats_t  stats
);

    // **************************************************
    // Statistics counters
    // **************************************************

    // Every step is one executed cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            stats.cycles <= '0;
        end else if (core_step) begin
            stats.cycles <= stats.cycles + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stats.jumps <= '0;
        end else if (core_step && core_stat.is_jump) begin
            stats.jumps <= stats.jumps + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stats.branches <= '0;
        end else if (core_step && core_stat.is_branch) begin
            stats.branches <= stats.branches + 32'd1;
        end
    end

    // Taken branches only
    always_ff @(posedge clk) begin
        if (rst) begin
            stats.taken <= '0;
        end else if (core_step && core_stat.branched) begin
            stats.taken <= stats.taken + 32'd1;
        end
    end

endmodule

`default_nettype wire

/* hw/seg_display.sv */
`timescale 1ns/1ps
`default_nettype none

module seg_display
    import board_pkg::*;
    import core_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  disp_sel_e    disp_sel,
    input  exec_stats_t  stats,
    input  core_status_t core_stat,
    output logic [7:0]   seg_n,
    output logic [7:0]   an_n
);

    localparam int DIGIT_W = $clog2(NUM_DIGITS);

    logic               scan_tick;
    logic [DIGIT_W-1:0] digit;
    logic [31:0]        disp_word;
    logic [3:0]         nibble;

    // Hex digit to active-low segments {dp, g, f, e, d, c, b, a}.
    function automatic logic [7:0] hex_to_seg(input logic [3:0] hex);
        logic [7:0] seg;
        case (hex)
            4'h0: seg = 8'hc0;
            4'h1: seg = 8'hf9;
            4'h2: seg = 8'ha4;
            4'h3: seg = 8'hb0;
            4'h4: seg = 8'h99;
            4'h5: seg = 8'h92;
            4'h6: seg = 8'h82;
            4'h7: seg = 8'hf8;
            4'h8: seg = 8'h80;
            4'h9: seg = 8'h90;
            4'ha: seg = 8'h88;
            4'hb: seg = 8'h83;
            4'hc: seg = 8'hc6;
            4'hd: seg = 8'ha1;
            4'he: seg = 8'h86;
            default: seg = 8'h8e;
        endcase
        return seg;
    endfunction

    // **************************************************
    // Source select
    // **************************************************
    always_comb begin
        case (disp_sel)
            DISP_CORE:     disp_word = core_stat.display;
            DISP_CYCLES:   disp_word = stats.cycles;
            DISP_JUMPS:    disp_word = stats.jumps;
            DISP_BRANCHES: disp_word = stats.branches;
            DISP_TAKEN:    disp_word = stats.taken;
            DISP_PC:       disp_word = core_stat.pc;
            DISP_REG:      disp_word = core_stat.reg_data;
            DISP_MEM:      disp_word = core_stat.mem_data;
            default:       disp_word = core_stat.display;
        endcase
    end

    // **************************************************
    // Digit scan
    // **************************************************
    rate_divider #(
        .DIV(SCAN_DIV)
    ) u_scan_div (
        .clk  (clk),
        .rst  (rst),
        .tick (scan_tick)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            digit <= '0;
        end else if (scan_tick) begin
            if (digit == DIGIT_W'(NUM_DIGITS - 1)) begin
                digit <= '0;
            end else begin
                digit <= digit + 1'b1;
            end
        end
    end

    assign nibble = disp_word[digit*4 +: 4];

    // Anode and segments registered together so they stay aligned.
    always_ff @(posedge clk) begin
        if (rst) begin
            an_n  <= 8'hfe;
            seg_n <= 8'hff;
        end else begin
            an_n  <= ~(8'd1 << digit);
            seg_n <= hex_to_seg(nibble);
        end
    end

endmodule

`default_nettype wire

/* hw/board_shell.sv */
`timescale 1ns/1ps
`default_nettype none

module board_shell
    import board_pkg::*;
    import core_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          resume,
    input  logic [15:0]   swt,
    input  core_status_t  core_stat,
    output logic          core_step,
    output core_dbg_req_t core_dbg,
    output logic [7:0]    seg_n,
    output logic [7:0]    an_n
);

    logic        freq_sel;
    disp_sel_e   disp_sel;
    logic        resume_pulse;
    logic        fast_tick;
    logic        slow_tick;
    logic        step_tick;
    exec_stats_t stats;

    // **************************************************
    // Board inputs
    // **************************************************
    board_inputs u_inputs (
        .clk          (clk),
        .rst          (rst),
        .swt          (swt),
        .resume       (resume),
        .freq_sel     (freq_sel),
        .disp_sel     (disp_sel),
        .core_dbg     (core_dbg),
        .resume_pulse (resume_pulse)
    );

    // **************************************************
    // Step pacing
    // **************************************************
    rate_divider #(
        .DIV(CORE_FAST_DIV)
    ) u_fast_div (
        .clk  (clk),
        .rst  (rst),
        .tick (fast_tick)
    );

    rate_divider #(
        .DIV(CORE_SLOW_DIV)
    ) u_slow_div (
        .clk  (clk),
        .rst  (rst),
        .tick (slow_tick)
    );

    // Switch 0 picks the slow rate.
    assign step_tick = freq_sel ? slow_tick : fast_tick;

    run_control u_run_ctrl (
        .clk          (clk),
        .rst          (rst),
        .tick         (step_tick),
        .halt         (core_stat.halt),
        .resume_pulse (resume_pulse),
        .core_step    (core_step)
    );

    // **************************************************
    // Statistics and display
    // **************************************************
    exec_counters u_counters (
        .clk       (clk),
        .rst       (rst),
        .core_step (core_step),
        .core_stat (core_stat),
        .stats     (stats)
    );

    seg_display u_display (
        .clk       (clk),
        .rst       (rst),
        .disp_sel  (disp_sel),
        .stats     (stats),
        .core_stat (core_stat),
        .seg_n     (seg_n),
        .an_n      (an_n)
    );

endmodule

`default_nettype wire

/* testbench/board_shell_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module board_shell_chk
    import core_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        core_step,
    input logic        halt,
    input logic        resume_pulse,
    input logic [7:0]  an_n,
    input exec_stats_t stats
);

    int unsigned fail_count = 0;

    // Stopped from a halted step until the next resume pulse.
    logic stopped;

    always_ff @(posedge clk) begin
        if (rst) begin
            stopped <= 1'b0;
        end else if (resume_pulse) begin
            stopped <= 1'b0;
        end else if (core_step && halt) begin
            stopped <= 1'b1;
        end
    end

    // **************************************************
    // Display scan
    // **************************************************
    an_one_low: assert property (@(posedge clk) disable iff (rst) $onehot(~an_n))
        else begin
            fail_count++;
            $error("an_n does not select exactly one digit");
        end

    // **************************************************
    // Step strobe and run state
    // **************************************************
    step_only_running: assert property (@(posedge clk) disable iff (rst)
        stopped |-> !core_step)
        else begin
            fail_count++;
            $error("core_step high while run control is stopped");
        end

    step_one_cycle: assert property (@(posedge clk) disable iff (rst)
        core_step |=> !core_step)
        else begin
            fail_count++;
            $error("core_step wider than one cycle");
        end

    resume_one_cycle: assert property (@(posedge clk) disable iff (rst)
        resume_pulse |=> !resume_pulse)
        else begin
            fail_count++;
            $error("resume pulse wider than one cycle");
        end

    // Cycle counter moves on steps only.
    cycles_count: assert property (@(posedge clk) disable iff (rst)
        core_step |=> stats.cycles == $past(stats.cycles) + 32'd1)
        else begin
            fail_count++;
            $error("cycle counter missed a step");
        end

    cycles_hold: assert property (@(posedge clk) disable iff (rst)
        !core_step |=> stats.cycles == $past(stats.cycles))
        else begin
            fail_count++;
            $error("cycle counter moved without a step");
        end

endmodule

bind board_shell board_shell_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .core_step    (core_step),
    .halt         (core_stat.halt),
    .resume_pulse (resume_pulse),
    .an_n         (an_n),
    .stats        (stats)
);

`default_nettype wire

/* testbench/tb_board_shell.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_board_shell
    import board_pkg::*;
    import core_pkg::*;
();

    logic          clk = 1'b0;
    logic          rst;
    logic          resume;
    logic [15:0]   swt;
    core_status_t  core_stat;
    logic          core_step;
    core_dbg_req_t core_dbg;
    logic [7:0]    seg_n;
    logic [7:0]    an_n;
    logic          halt_req;
    logic [31:0]   rng;
    exec_stats_t   model_stats;
    int            checks;
    int            errors;

    board_shell i_dut (
        .clk       (clk),
        .rst       (rst),
        .resume    (resume),
        .swt       (swt),
        .core_stat (core_stat),
        .core_step (core_step),
        .core_dbg  (core_dbg),
        .seg_n     (seg_n),
        .an_n      (an_n)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Lit segments {g..a} of each hex digit, inverted for the board.
    function automatic logic [7:0] seg_pattern(input logic [3:0] hex);
        logic [6:0] lit [16];
        lit = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
                7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
        return ~{1'b0, lit[hex]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, want);
        end
    endtask

    // Counts falling edges up to and including the next step.
    task automatic wait_step(input int limit, output int n);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (core_step !== 1'b1 && n < limit);
        checks++;
        if (core_step !== 1'b1) begin
            errors++;
            $display("Timeout: no core_step within %0d cycles", limit);
        end
    endtask

    task automatic drive_swt(input logic [15:0] v);
        @(posedge clk);
        #1;
        swt = v;
    endtask

    task automatic scan_check(input logic [31:0] word);
        int          digit;
        int          prev;
        int          held;
        int          moves;
        logic [7:0]  seen;
        logic [31:0] shifted;
        prev  = -1;
        held  = 0;
        moves = 0;
        seen  = '0;
        repeat ((NUM_DIGITS + 2) * SCAN_DIV) begin
            @(negedge clk);
            digit = -1;
            for (int i = 0; i < NUM_DIGITS; i++) begin
                if (an_n[i] == 1'b0) digit = i;
            end
            if (digit >= 0) begin
                shifted = word >> (4 * digit);
                check_value("seg_n", {24'd0, seg_n}, {24'd0, seg_pattern(shifted[3:0])});
                seen[digit] = 1'b1;
            end
            if (digit != prev && prev >= 0) begin
                check_value("an_n digit", digit, (prev + 1) % NUM_DIGITS);
                if (moves > 0) check_value("digit hold", held, SCAN_DIV);
                moves++;
                held = 0;
            end
            prev = digit;
            held++;
        end
        check_value("digits scanned", {24'd0, seen}, 32'hff);
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) $display("Test %s: ok", name);
        else $display("Test %s: %0d errors", name, errors - err_start);
    endtask

    // **************************************************
    // Core model
    // **************************************************
    always begin
        @(posedge clk);
        #1;
        if (rst !== 1'b0 || core_step !== 1'b1) begin
            core_stat.halt      = 1'b0;
            core_stat.is_jump   = 1'b0;
            core_stat.is_branch = 1'b0;
            core_stat.branched  = 1'b0;
        end else begin
            rng = lcg_next(rng);
            core_stat.halt      = halt_req;
            core_stat.is_jump   = rng[28];
            core_stat.is_branch = rng[29];
            core_stat.branched  = rng[29] & rng[30];
            model_stats.cycles   = model_stats.cycles + 32'd1;
            model_stats.jumps    = model_stats.jumps + {31'd0, rng[28]};
            model_stats.branches = model_stats.branches + {31'd0, rng[29]};
            model_stats.taken    = model_stats.taken + {31'd0, rng[29] & rng[30]};
        end
    end

    initial begin
        #200us;
        $display("Watchdog expired before the tests completed");
        $display("Simulation failed");
        $finish;
    end

    // **************************************************
    // Tests
    // **************************************************
    initial begin
        int               n;
        int               err_start;
        logic [15:0]      v;
        logic [31:0]      words [4];
        disp_sel_e        srcs [4];
        rst         = 1'b1;
        resume      = 1'b0;
        swt         = '0;
        core_stat   = '0;
        halt_req    = 1'b0;
        rng         = 32'h848e;
        model_stats = '0;
        checks      = 0;
        errors      = 0;

        err_start = errors;
        repeat (16) begin
            @(posedge clk);
            #1;
            check_value("core_step", {31'd0, core_step}, 32'd0);
        end
        rst = 1'b0;
        wait_step(2 * CORE_FAST_DIV + 2, n);
        repeat (3) begin
            wait_step(2 * CORE_FAST_DIV, n);
            check_value("core_step period", n, CORE_FAST_DIV);
        end
        drive_swt(16'h0001);
        repeat (4) @(negedge clk);
        wait_step(2 * CORE_SLOW_DIV, n);
        repeat (3) begin
            wait_step(2 * CORE_SLOW_DIV, n);
            check_value("core_step period", n, CORE_SLOW_DIV);
        end
        report_test("step pacing", err_start);

        err_start = errors;
        drive_swt(16'h0000);
        repeat (4) @(negedge clk);
        wait_step(2 * CORE_FAST_DIV, n);
        halt_req = 1'b1;
        wait_step(2 * CORE_FAST_DIV, n);
        halt_req = 1'b0;
        repeat (50) begin
            @(negedge clk);
            check_value("core_step", {31'd0, core_step}, 32'd0);
        end
        @(posedge clk);
        #1;
        resume = 1'b1;
        // Pulse after 3 cycles, running one edge later, then one tick period.
        wait_step(CORE_FAST_DIV + 4, n);
        @(posedge clk);
        #1;
        resume = 1'b0;
        report_test("halt and resume", err_start);

        err_start = errors;
        @(negedge clk);
        halt_req = 1'b1;
        wait_step(2 * CORE_FAST_DIV, n);
        halt_req = 1'b0;
        for (int s = 1; s <= 4; s++) begin
            drive_swt({12'd0, 3'(s), 1'b0});
            repeat (4) @(negedge clk);
            case (s)
                1: scan_check(model_stats.cycles);
                2: scan_check(model_stats.jumps);
                3: scan_check(model_stats.branches);
                default: scan_check(model_stats.taken);
            endcase
        end
        report_test("statistics display", err_start);

        err_start = errors;
        repeat (16) begin
            rng = lcg_next(rng);
            v = rng[31:16];
            drive_swt(v);
            // Decoded outputs follow two edges after the switch change.
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_value("core_dbg.reg_idx", {27'd0, core_dbg.reg_idx}, {27'd0, v[15:11]});
            check_value("core_dbg.mem_addr", core_dbg.mem_addr, 32'(v[15:6]) * 32'd4);
        end
        report_test("debug request", err_start);

        err_start = errors;
        for (int i = 0; i < 4; i++) begin
            rng = lcg_next(rng);
            words[i] = rng;
        end
        srcs = '{DISP_CORE, DISP_PC, DISP_REG, DISP_MEM};
        @(posedge clk);
        #1;
        core_stat.display  = words[0];
        core_stat.pc       = words[1];
        core_stat.reg_data = words[2];
        core_stat.mem_data = words[3];
        for (int i = 0; i < 4; i++) begin
            drive_swt({12'd0, srcs[i], 1'b0});
            repeat (4) @(negedge clk);
            scan_check(words[i]);
        end
        report_test("display scan and sources", err_start);

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, i_dut.u_chk.fail_count);
        if (errors == 0 && i_dut.u_chk.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hw/board_pkg.sv
hw/core_pkg.sv
hw/board_inputs.sv
hw/rate_divider.sv
hw/run_control.sv
hw/exec_counters.sv
hw/seg_display.sv
hw/board_shell.sv
testbench/board_shell_chk.sv
testbench/tb_board_shell.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_board_shell \
    -f src.f -Mdir obj_dir || { echo "Build error"; exit 1; }

./obj_dir/Vtb_board_shell +verilator+error+limit+1000 \
    | tee /dev/stderr \
    | grep -q "^Simulation passed$" \
    && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }
